//--- bops_pkg.sv
package bops_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Basic operator set
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_ADD      = 4'd0,
		OP_SUB      = 4'd1,
		OP_MULT     = 4'd2,
		OP_L_ADD    = 4'd3,
		OP_L_SUB    = 4'd4,
		OP_L_MULT   = 4'd5,
		OP_L_MAC    = 4'd6,
		OP_L_MSU    = 4'd7,
		OP_L_SHL    = 4'd8,
		OP_L_SHR    = 4'd9,
		OP_NORM_L   = 4'd10,
		OP_L_ABS    = 4'd11,
		OP_L_NEGATE = 4'd12
	} op_t;

	// Saturation limits, 16-bit ones already sign-extended
	localparam logic [31:0] MAX_32 = 32'h7fff_ffff;
	localparam logic [31:0] MIN_32 = 32'h8000_0000;
	localparam logic [31:0] MAX_16 = 32'h0000_7fff;
	localparam logic [31:0] MIN_16 = 32'hffff_8000;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word and stage bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [3:0] rsvd;
		op_t        op;
		logic [7:0] dst;
		logic [7:0] src_a;
		logic [7:0] src_b;
	} instr_3a_t;

	// Shift form carries the count in place of the second source
	typedef struct packed {
		logic [3:0]        rsvd;
		op_t               op;
		logic [7:0]        dst;
		logic [7:0]        src;
		logic signed [7:0] shift;
	} instr_sh_t;

	typedef union packed {
		instr_3a_t ta;
		instr_sh_t sh;
	} instr_u;

	typedef struct packed {
		op_t               op;
		logic [7:0]        dst;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       c;
		logic signed [7:0] shift;
	} exec_t;

	typedef struct packed {
		logic [7:0]  dst;
		logic [31:0] value;
		logic        ovf;
	} result_t;

endpackage

//--- bus_pkg.sv
package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic slave port
	////////////////////////////////////////////////////////////////////////////

	localparam int WB_AW = 10;
	localparam int WB_DW = 32;

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////////////////////

	// Scratch memory sits in the words below this bit
	localparam int MEM_WIN_AW = 8;

	localparam logic [WB_AW-1:0] REG_CMD    = 10'h100;
	localparam logic [WB_AW-1:0] REG_STATUS = 10'h101;

	// Status word bits
	localparam int STAT_BUSY = 0;
	localparam int STAT_OVF  = 1;

endpackage

//--- host_port.sv
`timescale 1ns/1ps

module host_port (
	input  logic                        clock,
	input  logic                        i_rst,
	input  bus_pkg::wb_req_t            i_wb,
	output bus_pkg::wb_rsp_t            o_wb,
	output logic [bus_pkg::WB_AW-1:0]   o_mem_addr,
	output logic [bus_pkg::WB_DW-1:0]   o_mem_wdata,
	output logic                        o_mem_we,
	input  logic [bus_pkg::WB_DW-1:0]   i_mem_rdata,
	output logic                        o_issue,
	output bops_pkg::instr_u            o_cmd,
	input  logic                        i_busy,
	input  logic                        i_ovf,
	output logic                        o_ovf_clr
);

	logic                      mem_sel;
	logic                      cmd_sel;
	logic                      stat_sel;
	logic                      req;
	logic                      stall;
	logic                      go;
	logic                      ack_q;
	logic                      rd_pend;
	logic [bus_pkg::WB_DW-1:0] rdata_q;
	logic [bus_pkg::WB_DW-1:0] status;

	// Address decode
	assign mem_sel  = (i_wb.adr[bus_pkg::WB_AW-1:bus_pkg::MEM_WIN_AW] == '0);
	assign cmd_sel  = (i_wb.adr == bus_pkg::REG_CMD);
	assign stat_sel = (i_wb.adr == bus_pkg::REG_STATUS);

	// A new cycle, not the tail of one already acked
	assign req   = i_wb.cyc & i_wb.stb & ~ack_q;
	// Engine owns the memory while busy, status stays reachable
	assign stall = i_busy & (mem_sel | cmd_sel);
	assign go    = req & ~rd_pend & ~stall;

	always_comb
	begin
		status = '0;
		status[bus_pkg::STAT_BUSY] = i_busy;
		status[bus_pkg::STAT_OVF]  = i_ovf;
	end

	assign o_mem_addr  = i_wb.adr;
	assign o_mem_wdata = i_wb.dat;
	assign o_mem_we    = go & mem_sel & i_wb.we;

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			ack_q     <= 1'b0;
			rd_pend   <= 1'b0;
			o_issue   <= 1'b0;
			o_ovf_clr <= 1'b0;
		end
		else
		begin
			ack_q     <= 1'b0;
			rd_pend   <= 1'b0;
			o_issue   <= 1'b0;
			o_ovf_clr <= 1'b0;
			// Memory reads take one extra wait state for the RAM latency
			if (rd_pend)
				ack_q <= 1'b1;
			else if (go && mem_sel && !i_wb.we)
				rd_pend <= 1'b1;
			else if (go)
			begin
				ack_q     <= 1'b1;
				o_issue   <= cmd_sel & i_wb.we;
				o_ovf_clr <= stat_sel & i_wb.we;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rd_pend)
			rdata_q <= i_mem_rdata;
		else if (go)
			rdata_q <= stat_sel ? status : '0;
		if (go && cmd_sel && i_wb.we)
			o_cmd <= i_wb.dat;
	end

	assign o_wb.ack = ack_q;
	assign o_wb.dat = rdata_q;

endmodule

//--- scratch_mem.sv
`timescale 1ns/1ps

module scratch_mem #(
	parameter int MEM_AW = 8
) (
	input  logic              clock,
	input  logic [MEM_AW-1:0] i_host_addr,
	input  logic [31:0]       i_host_wdata,
	input  logic              i_host_we,
	input  logic [MEM_AW-1:0] i_eng_raddr,
	input  logic [MEM_AW-1:0] i_eng_waddr,
	input  logic [31:0]       i_eng_wdata,
	input  logic              i_eng_we,
	input  logic              i_busy,
	output logic [31:0]       o_rdata
);

	logic [31:0]       mem [0:(1<<MEM_AW)-1];
	logic [MEM_AW-1:0] raddr;
	logic [MEM_AW-1:0] waddr;
	logic [31:0]       wdata;
	logic              we;

	// Port select, engine while busy
	always_comb
	begin
		case (i_busy)
			1'b0: raddr = i_host_addr;
			1'b1: raddr = i_eng_raddr;
		endcase
	end

	always_comb
	begin
		case (i_busy)
			1'b0: waddr = i_host_addr;
			1'b1: waddr = i_eng_waddr;
		endcase
	end

	always_comb
	begin
		case (i_busy)
			1'b0: wdata = i_host_wdata;
			1'b1: wdata = i_eng_wdata;
		endcase
	end

	always_comb
	begin
		case (i_busy)
			1'b0: we = i_host_we;
			1'b1: we = i_eng_we;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (we)
			mem[waddr] <= wdata;
		o_rdata <= mem[raddr];
	end

endmodule

//--- op_decode.sv
`timescale 1ns/1ps

module op_decode #(
	parameter int MEM_AW = 8
) (
	input  logic              clock,
	input  logic              i_rst,
	input  logic              i_issue,
	input  bops_pkg::instr_u  i_cmd,
	output logic [MEM_AW-1:0] o_raddr,
	input  logic [31:0]       i_rdata,
	output bops_pkg::exec_t   o_exec,
	output logic              o_exec_valid
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_RD_A = 3'd1;
	localparam logic [2:0] ST_RD_B = 3'd2;
	localparam logic [2:0] ST_RD_C = 3'd3;
	localparam logic [2:0] ST_EXEC = 3'd4;

	logic [2:0]        step;
	bops_pkg::instr_u  cmd_q;
	logic              is_shift;
	logic [7:0]        addr_a;
	logic [7:0]        addr_b;
	logic [7:0]        raddr;
	logic signed [7:0] shift;
	logic [31:0]       a_q;
	logic [31:0]       b_q;

	// Fetch sequence A, B, then destination word as accumulator
	always_ff @(posedge clock)
	begin
		if (i_rst)
			step <= ST_IDLE;
		else
		begin
			case (step)
				ST_IDLE: if (i_issue) step <= ST_RD_A;
				ST_RD_A: step <= ST_RD_B;
				ST_RD_B: step <= ST_RD_C;
				ST_RD_C: step <= ST_EXEC;
				default: step <= ST_IDLE;
			endcase
		end
	end

	// Read data lags the address by one cycle
	always_ff @(posedge clock)
	begin
		if (i_issue)
			cmd_q <= i_cmd;
		if (step == ST_RD_B)
			a_q <= i_rdata;
		if (step == ST_RD_C)
			b_q <= i_rdata;
	end

	assign is_shift = (cmd_q.ta.op == bops_pkg::OP_L_SHL) ||
		(cmd_q.ta.op == bops_pkg::OP_L_SHR);

	// Shift form has no second source, so its slot rereads the first
	always_comb
	begin
		// Source A sits in the same field in both views
		addr_a = cmd_q.ta.src_a;
		if (is_shift)
		begin
			addr_b = cmd_q.sh.src;
			shift  = cmd_q.sh.shift;
		end
		else
		begin
			addr_b = cmd_q.ta.src_b;
			shift  = '0;
		end
		case (step)
			ST_RD_A: raddr = addr_a;
			ST_RD_B: raddr = addr_b;
			default: raddr = cmd_q.ta.dst;
		endcase
	end

	assign o_raddr = raddr[MEM_AW-1:0];

	assign o_exec_valid = (step == ST_EXEC);
	assign o_exec.op    = cmd_q.ta.op;
	assign o_exec.dst   = cmd_q.ta.dst;
	assign o_exec.a     = a_q;
	assign o_exec.b     = b_q;
	assign o_exec.c     = i_rdata;
	assign o_exec.shift = shift;

endmodule

//--- op_execute.sv
`timescale 1ns/1ps

module op_execute (
	input  logic              clock,
	input  logic              i_rst,
	input  bops_pkg::exec_t   i_exec,
	input  logic              i_exec_valid,
	output bops_pkg::result_t o_res,
	output logic              o_res_valid
);

	logic signed [15:0] a16;
	logic signed [15:0] b16;
	logic signed [31:0] prod;
	logic signed [31:0] lmult;
	logic               lmult_ovf;
	logic signed [8:0]  lcount;
	logic [5:0]         lsh;
	logic [4:0]         rsh;
	logic signed [63:0] shl_wide;
	logic signed [31:0] shr_val;
	logic [31:0]        mag;
	logic [4:0]         norm;
	logic [31:0]        value;
	logic               ovf;

	// {overflow, value} for a 16-bit result
	function automatic logic [32:0] sat16(input logic signed [32:0] x);
		if (x[32:15] != {18{x[32]}})
			return {1'b1, x[32] ? bops_pkg::MIN_16 : bops_pkg::MAX_16};
		return {1'b0, x[31:0]};
	endfunction

	function automatic logic [32:0] sat32(input logic signed [32:0] x);
		if (x[32] != x[31])
			return {1'b1, x[32] ? bops_pkg::MIN_32 : bops_pkg::MAX_32};
		return {1'b0, x[31:0]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Shared terms
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		a16       = i_exec.a[15:0];
		b16       = i_exec.b[15:0];
		prod      = a16 * b16;
		// Only -32768 * -32768 reaches 2^30
		lmult_ovf = (prod == 32'sh4000_0000);
		lmult     = lmult_ovf ? bops_pkg::MAX_32 : prod <<< 1;

		// Positive count means left, L_shr mirrors it
		lcount = {i_exec.shift[7], i_exec.shift};
		if (i_exec.op == bops_pkg::OP_L_SHR)
			lcount = -lcount;
		lsh      = (lcount > 9'sd32) ? 6'd32 : lcount[5:0];
		rsh      = (lcount < -9'sd31) ? 5'd31 : 5'(-lcount);
		shl_wide = 64'($signed(i_exec.a)) <<< lsh;
		shr_val  = $signed(i_exec.a) >>> rsh;

		// Leading sign bits by priority search
		mag  = i_exec.a[31] ? ~i_exec.a : i_exec.a;
		norm = 5'd0;
		for (int i = 0; i < 31; i++)
			if (mag[i])
				norm = 5'(30 - i);
		if (i_exec.a == '1)
			norm = 5'd31;
	end

	////////////////////////////////////////////////////////////////////////////
	// Operator select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		value = '0;
		ovf   = 1'b0;
		case (i_exec.op)
			bops_pkg::OP_ADD:    {ovf, value} = sat16(33'(a16) + 33'(b16));
			bops_pkg::OP_SUB:    {ovf, value} = sat16(33'(a16) - 33'(b16));
			bops_pkg::OP_MULT:   {ovf, value} = sat16(33'(prod >>> 15));
			bops_pkg::OP_L_ADD:
				{ovf, value} = sat32(33'($signed(i_exec.a)) + 33'($signed(i_exec.b)));
			bops_pkg::OP_L_SUB:
				{ovf, value} = sat32(33'($signed(i_exec.a)) - 33'($signed(i_exec.b)));
			bops_pkg::OP_L_MULT: {ovf, value} = {lmult_ovf, lmult};
			bops_pkg::OP_L_MAC:
			begin
				{ovf, value} = sat32(33'($signed(i_exec.c)) + 33'(lmult));
				ovf = ovf | lmult_ovf;
			end
			bops_pkg::OP_L_MSU:
			begin
				{ovf, value} = sat32(33'($signed(i_exec.c)) - 33'(lmult));
				ovf = ovf | lmult_ovf;
			end
			bops_pkg::OP_L_SHL, bops_pkg::OP_L_SHR:
			begin
				if (lcount <= 9'sd0)
					value = shr_val;
				else if (shl_wide[63:31] != {33{shl_wide[31]}})
				begin
					ovf   = 1'b1;
					value = i_exec.a[31] ? bops_pkg::MIN_32 : bops_pkg::MAX_32;
				end
				else
					value = shl_wide[31:0];
			end
			bops_pkg::OP_NORM_L: value = {27'd0, norm};
			bops_pkg::OP_L_ABS:
				value = (i_exec.a == bops_pkg::MIN_32) ? bops_pkg::MAX_32 :
					(i_exec.a[31] ? -i_exec.a : i_exec.a);
			bops_pkg::OP_L_NEGATE:
				value = (i_exec.a == bops_pkg::MIN_32) ? bops_pkg::MAX_32 : -i_exec.a;
			default: value = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
			o_res_valid <= 1'b0;
		else
			o_res_valid <= i_exec_valid;
		if (i_exec_valid)
			o_res <= '{dst: i_exec.dst, value: value, ovf: ovf};
	end

endmodule

//--- op_result.sv
`timescale 1ns/1ps

module op_result #(
	parameter int MEM_AW = 8
) (
	input  logic              clock,
	input  logic              i_rst,
	input  bops_pkg::result_t i_res,
	input  logic              i_res_valid,
	input  logic              i_issue,
	input  logic              i_ovf_clr,
	output logic [MEM_AW-1:0] o_waddr,
	output logic [31:0]       o_wdata,
	output logic              o_we,
	output logic              o_busy,
	output logic              o_ovf
);

	// Writeback happens in the last busy cycle
	assign o_waddr = i_res.dst[MEM_AW-1:0];
	assign o_wdata = i_res.value;
	assign o_we    = i_res_valid;

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			o_busy <= 1'b0;
			o_ovf  <= 1'b0;
		end
		else
		begin
			if (i_issue)
				o_busy <= 1'b1;
			else if (i_res_valid)
				o_busy <= 1'b0;
			// A new overflow wins over a clear in the same cycle
			if (i_ovf_clr)
				o_ovf <= 1'b0;
			if (i_res_valid && i_res.ovf)
				o_ovf <= 1'b1;
		end
	end

endmodule

//--- dsp_top.sv
`timescale 1ns/1ps

module dsp_top #(
	parameter int MEM_AW = 8
) (
	input  logic             clock,
	input  logic             i_rst,
	input  bus_pkg::wb_req_t i_wb,
	output bus_pkg::wb_rsp_t o_wb
);

	logic [bus_pkg::WB_AW-1:0] host_addr;
	logic [31:0]               host_wdata;
	logic                      host_we;
	logic [31:0]               mem_rdata;
	logic                      issue;
	bops_pkg::instr_u          cmd;
	logic                      busy;
	logic                      ovf;
	logic                      ovf_clr;
	logic [MEM_AW-1:0]         eng_raddr;
	bops_pkg::exec_t           exec;
	logic                      exec_valid;
	bops_pkg::result_t         res;
	logic                      res_valid;
	logic [MEM_AW-1:0]         eng_waddr;
	logic [31:0]               eng_wdata;
	logic                      eng_we;

	////////////////////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////////////////////

	host_port host_i (
		.clock(clock), .i_rst(i_rst), .i_wb(i_wb), .o_wb(o_wb),
		.o_mem_addr(host_addr), .o_mem_wdata(host_wdata), .o_mem_we(host_we),
		.i_mem_rdata(mem_rdata), .o_issue(issue), .o_cmd(cmd),
		.i_busy(busy), .i_ovf(ovf), .o_ovf_clr(ovf_clr)
	);

	scratch_mem #(.MEM_AW(MEM_AW)) mem_i (
		.clock(clock), .i_host_addr(host_addr[MEM_AW-1:0]),
		.i_host_wdata(host_wdata), .i_host_we(host_we), .i_eng_raddr(eng_raddr),
		.i_eng_waddr(eng_waddr), .i_eng_wdata(eng_wdata), .i_eng_we(eng_we),
		.i_busy(busy), .o_rdata(mem_rdata)
	);

	////////////////////////////////////////////////////////////////////////////
	// Engine, fetch then execute then writeback
	////////////////////////////////////////////////////////////////////////////

	op_decode #(.MEM_AW(MEM_AW)) decode_i (
		.clock(clock), .i_rst(i_rst), .i_issue(issue), .i_cmd(cmd),
		.o_raddr(eng_raddr), .i_rdata(mem_rdata),
		.o_exec(exec), .o_exec_valid(exec_valid)
	);

	op_execute execute_i (
		.clock(clock), .i_rst(i_rst), .i_exec(exec), .i_exec_valid(exec_valid),
		.o_res(res), .o_res_valid(res_valid)
	);

	op_result #(.MEM_AW(MEM_AW)) result_i (
		.clock(clock), .i_rst(i_rst), .i_res(res), .i_res_valid(res_valid),
		.i_issue(issue), .i_ovf_clr(ovf_clr),
		.o_waddr(eng_waddr), .o_wdata(eng_wdata), .o_we(eng_we),
		.o_busy(busy), .o_ovf(ovf)
	);

endmodule

//--- dsp_chk.sv
`timescale 1ns/1ps

module dsp_chk (
	input logic clock,
	input logic i_rst,
	input logic i_cyc,
	input logic i_ack,
	input logic i_busy,
	input logic i_eng_we
);

	logic [3:0] busy_len;

	// Cycles spent busy so far
	always_ff @(posedge clock)
	begin
		if (i_rst || !i_busy)
			busy_len <= 4'd0;
		else if (busy_len != 4'hf)
			busy_len <= busy_len + 4'd1;
	end

	ack_needs_cyc: assert property (@(posedge clock) disable iff (i_rst)
		i_ack |-> i_cyc)
		else $error("ack high with cyc low");

	ack_one_cycle: assert property (@(posedge clock) disable iff (i_rst)
		i_ack |=> !i_ack)
		else $error("ack held for two cycles");

	busy_bounded: assert property (@(posedge clock) disable iff (i_rst)
		busy_len <= 4'd6)
		else $error("busy held longer than 6 cycles");

	we_only_busy: assert property (@(posedge clock) disable iff (i_rst)
		i_eng_we |-> i_busy)
		else $error("engine write while idle");

endmodule

bind dsp_top dsp_chk chk_i (
	.clock(clock),
	.i_rst(i_rst),
	.i_cyc(i_wb.cyc),
	.i_ack(o_wb.ack),
	.i_busy(busy),
	.i_eng_we(eng_we)
);

//--- dsp_tb_ref.svh
`ifndef DSP_TB_REF_SVH
`define DSP_TB_REF_SVH

// {overflow, value} for a 16-bit result, stored sign-extended
function automatic logic [32:0] clamp16(input longint v);
	if (v > 64'sd32767)
		return {1'b1, 32'h0000_7fff};
	if (v < -64'sd32768)
		return {1'b1, 32'hffff_8000};
	return {1'b0, 32'(v)};
endfunction

function automatic logic [32:0] clamp32(input longint v);
	if (v > 64'sd2147483647)
		return {1'b1, 32'h7fff_ffff};
	if (v < -64'sd2147483648)
		return {1'b1, 32'h8000_0000};
	return {1'b0, 32'(v)};
endfunction

// Expected {overflow, value} of one operator, G.729 basic op rules
function automatic logic [32:0] expected_result(input bops_pkg::op_t op,
	input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
	input logic signed [7:0] shift);
	longint     sa;
	longint     sb;
	longint     la;
	longint     p;
	longint     v;
	int         n;
	logic [32:0] lm;
	logic [32:0] t;
	logic [31:0] x;
	sa = $signed(a[15:0]);
	sb = $signed(b[15:0]);
	la = $signed(a);
	p  = sa * sb;
	// Doubled product, only 0x8000 squared does not fit
	if (p == 64'sd1073741824)
		lm = {1'b1, 32'h7fff_ffff};
	else
		lm = {1'b0, 32'(p * 2)};
	case (op)
		bops_pkg::OP_ADD:    return clamp16(sa + sb);
		bops_pkg::OP_SUB:    return clamp16(sa - sb);
		bops_pkg::OP_MULT:   return clamp16(p >>> 15);
		bops_pkg::OP_L_ADD:  return clamp32(la + longint'($signed(b)));
		bops_pkg::OP_L_SUB:  return clamp32(la - longint'($signed(b)));
		bops_pkg::OP_L_MULT: return lm;
		bops_pkg::OP_L_MAC, bops_pkg::OP_L_MSU:
		begin
			v = $signed(lm[31:0]);
			if (op == bops_pkg::OP_L_MAC)
				t = clamp32(longint'($signed(c)) + v);
			else
				t = clamp32(longint'($signed(c)) - v);
			return {t[32] | lm[32], t[31:0]};
		end
		bops_pkg::OP_L_SHL, bops_pkg::OP_L_SHR:
		begin
			n = shift;
			if (op == bops_pkg::OP_L_SHR)
				n = -n;
			if (n <= 0)
			begin
				if (n < -31)
					n = -31;
				return {1'b0, 32'(la >>> (-n))};
			end
			if (n > 32)
				n = 32;
			v = la <<< n;
			if (v > 64'sd2147483647 || v < -64'sd2147483648)
				return {1'b1, a[31] ? 32'h8000_0000 : 32'h7fff_ffff};
			return {1'b0, 32'(v)};
		end
		bops_pkg::OP_NORM_L:
		begin
			if (a == 32'd0)
				return 33'd0;
			if (a == 32'hffff_ffff)
				return 33'd31;
			n = 0;
			x = a;
			while (x[31] == x[30])
			begin
				x = x << 1;
				n++;
			end
			return {1'b0, 32'(n)};
		end
		bops_pkg::OP_L_ABS:
		begin
			if (a == 32'h8000_0000)
				return {1'b0, 32'h7fff_ffff};
			return {1'b0, a[31] ? 32'(-la) : a};
		end
		bops_pkg::OP_L_NEGATE:
		begin
			if (a == 32'h8000_0000)
				return {1'b0, 32'h7fff_ffff};
			return {1'b0, 32'(-la)};
		end
		default: return 33'd0;
	endcase
endfunction

`endif

//--- dsp_tb.sv
`timescale 1ns/1ps

module dsp_tb;

	localparam int N_RAND = 8;
	// About 200 operations of 20 cycles plus the memory sweep
	localparam int TIMEOUT_CYCLES = 200 * 20 + 4000;

	logic             clock;
	logic             i_rst;
	bus_pkg::wb_req_t i_wb;
	bus_pkg::wb_rsp_t o_wb;

	integer      seed;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          test_base;
	int          cycles;
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];
	string       name_q[$];
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;
	string       cmp_name;
	logic [31:0] words[0:255];

	`include "dsp_tb_ref.svh"

	dsp_top #(.MEM_AW(8)) dut_i (
		.clock(clock),
		.i_rst(i_rst),
		.i_wb(i_wb),
		.o_wb(o_wb)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout, run exceeded its limit of %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		while (got_q.size() > 0)
		begin
			cmp_got  = got_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_name = name_q.pop_front();
			checks++;
			if (cmp_got !== cmp_exp)
			begin
				errors++;
				$display("[ERROR] %s got 0x%08h expected 0x%08h",
					cmp_name, cmp_got, cmp_exp);
			end
		end
	end

	task automatic expect_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		got_q.push_back(got);
		exp_q.push_back(exp);
		name_q.push_back(name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone tasks entered and left on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_cycle(input logic we, input logic [9:0] adr,
		input logic [31:0] dat, output logic [31:0] rdat);
		int waited;
		waited    = 0;
		i_wb.cyc  = 1'b1;
		i_wb.stb  = 1'b1;
		i_wb.we   = we;
		i_wb.adr  = adr;
		i_wb.dat  = dat;
		@(negedge clock);
		while (!o_wb.ack && waited < 64)
		begin
			waited++;
			@(negedge clock);
		end
		rdat = o_wb.dat;
		// Cycle stays up over the rising edge that samples ack
		if (o_wb.ack)
			@(negedge clock);
		else
		begin
			errors++;
			$display("Bus stalled, no ack at address 0x%03h", adr);
		end
		i_wb.cyc = 1'b0;
		i_wb.stb = 1'b0;
		i_wb.we  = 1'b0;
	endtask

	task automatic wb_write(input logic [9:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [9:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'd0, dat);
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int          polls;
		polls = 0;
		st    = 32'd1;
		while (st[bus_pkg::STAT_BUSY] && polls < 32)
		begin
			wb_read(bus_pkg::REG_STATUS, st);
			polls++;
		end
		if (st[bus_pkg::STAT_BUSY])
		begin
			errors++;
			$display("Engine stayed busy after a command");
		end
	endtask

	// Shift operators take the count in place of the second source
	task automatic issue_op(input bops_pkg::op_t op, input logic [7:0] dst,
		input logic [7:0] src_a, input logic [7:0] src_b_or_shift);
		bops_pkg::instr_u ins;
		ins = '0;
		if (op == bops_pkg::OP_L_SHL || op == bops_pkg::OP_L_SHR)
		begin
			ins.sh.op    = op;
			ins.sh.dst   = dst;
			ins.sh.src   = src_a;
			ins.sh.shift = src_b_or_shift;
		end
		else
		begin
			ins.ta.op    = op;
			ins.ta.dst   = dst;
			ins.ta.src_a = src_a;
			ins.ta.src_b = src_b_or_shift;
		end
		wb_write(bus_pkg::REG_CMD, ins);
	endtask

	// Operands at 0x10 and 0x11 with accumulator and result at 0x20
	task automatic run_and_check(input string name, input bops_pkg::op_t op,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
		input logic [7:0] shift);
		logic [32:0] exp;
		logic [31:0] got;
		logic [31:0] st;
		exp = expected_result(op, a, b, c, shift);
		wb_write(10'h010, a);
		wb_write(10'h011, b);
		wb_write(10'h020, c);
		wb_write(bus_pkg::REG_STATUS, 32'd0);
		if (op == bops_pkg::OP_L_SHL || op == bops_pkg::OP_L_SHR)
			issue_op(op, 8'h20, 8'h10, shift);
		else
			issue_op(op, 8'h20, 8'h10, 8'h11);
		wait_idle();
		wb_read(10'h020, got);
		expect_word({name, " result"}, got, exp[31:0]);
		wb_read(bus_pkg::REG_STATUS, st);
		expect_word({name, " status.ovf"}, {31'd0, st[bus_pkg::STAT_OVF]},
			{31'd0, exp[32]});
	endtask

	task automatic end_test(input string title);
		while (got_q.size() > 0)
			@(posedge clock);
		@(negedge clock);
		tests_run++;
		if (errors == test_base)
			$display("test %-14s ok", title);
		else
		begin
			tests_failed++;
			$display("test %-14s failed, %0d errors", title, errors - test_base);
		end
		test_base = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       c;
		logic [31:0]       rd;
		logic [7:0]        sh;
		logic [32:0]       e1;
		logic [32:0]       e2;
		logic [32:0]       e3;
		logic [32:0]       e4;
		bops_pkg::op_t     op;
		seed         = 32'h3d11_9ca4;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_base    = 0;
		i_rst        = 1'b1;
		i_wb         = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		i_rst = 1'b0;

		// Memory load and read-back
		for (int i = 0; i < 256; i++)
		begin
			words[i] = $random(seed);
			wb_write(10'(i), words[i]);
		end
		for (int i = 0; i < 256; i++)
		begin
			wb_read(10'(i), rd);
			expect_word($sformatf("mem[%02h]", i), rd, words[i]);
		end
		end_test("memory");

		// Every operator on random operands
		for (int k = 0; k < 13; k++)
		begin
			op = bops_pkg::op_t'(k);
			for (int n = 0; n < N_RAND; n++)
			begin
				a  = $random(seed);
				b  = $random(seed);
				c  = $random(seed);
				sh = 8'($random(seed) % 41);
				run_and_check(op.name(), op, a, b, c, sh);
			end
		end
		end_test("random ops");

		// Saturation corners
		run_and_check("mult min", bops_pkg::OP_MULT, 32'h8000, 32'h8000, 0, 0);
		run_and_check("L_mult min", bops_pkg::OP_L_MULT, 32'h8000, 32'h8000, 0, 0);
		run_and_check("L_mac sat", bops_pkg::OP_L_MAC, 32'h7fff, 32'h7fff, 32'h7fff_0000, 0);
		run_and_check("L_msu sat", bops_pkg::OP_L_MSU, 32'h7fff, 32'h7fff, 32'h8000_0000, 0);
		run_and_check("add max", bops_pkg::OP_ADD, 32'h7fff, 32'h0001, 0, 0);
		run_and_check("sub min", bops_pkg::OP_SUB, 32'h8000, 32'h0001, 0, 0);
		run_and_check("L_add max", bops_pkg::OP_L_ADD, 32'h7fff_ffff, 32'd1, 0, 0);
		run_and_check("L_abs min", bops_pkg::OP_L_ABS, 32'h8000_0000, 0, 0, 0);
		run_and_check("L_negate min", bops_pkg::OP_L_NEGATE, 32'h8000_0000, 0, 0, 0);
		run_and_check("L_shl 40", bops_pkg::OP_L_SHL, 32'd1, 0, 0, 8'd40);
		run_and_check("L_shl edge", bops_pkg::OP_L_SHL, 32'h4000_0000, 0, 0, 8'd1);
		run_and_check("L_shl neg", bops_pkg::OP_L_SHL, 32'h8000_0000, 0, 0, -8'sd5);
		run_and_check("L_shr 100", bops_pkg::OP_L_SHR, 32'hffff_ffff, 0, 0, 8'd100);
		run_and_check("L_shr neg", bops_pkg::OP_L_SHR, 32'hc000_0000, 0, 0, -8'sd3);
		run_and_check("norm_l 0", bops_pkg::OP_NORM_L, 32'd0, 0, 0, 0);
		run_and_check("norm_l -1", bops_pkg::OP_NORM_L, 32'hffff_ffff, 0, 0, 0);
		run_and_check("norm_l 1", bops_pkg::OP_NORM_L, 32'd1, 0, 0, 0);
		// Rerun an overflowing corner so the status write has a flag to clear
		run_and_check("mult min", bops_pkg::OP_MULT, 32'h8000, 32'h8000, 0, 0);
		wb_write(bus_pkg::REG_STATUS, 32'd0);
		wb_read(bus_pkg::REG_STATUS, rd);
		expect_word("status.ovf after clear", {31'd0, rd[bus_pkg::STAT_OVF]}, 32'd0);
		end_test("corners");

		// Back-pressure on a memory write right behind a command
		a = $random(seed);
		b = $random(seed);
		wb_write(10'h010, a);
		wb_write(10'h011, b);
		issue_op(bops_pkg::OP_L_ADD, 8'h20, 8'h10, 8'h11);
		wb_read(bus_pkg::REG_STATUS, rd);
		expect_word("status.busy", {31'd0, rd[bus_pkg::STAT_BUSY]}, 32'd1);
		wb_write(10'h030, 32'h5a5a_0f0f);
		wait_idle();
		e1 = expected_result(bops_pkg::OP_L_ADD, a, b, 0, 0);
		wb_read(10'h020, rd);
		expect_word("L_add under stall", rd, e1[31:0]);
		wb_read(10'h030, rd);
		expect_word("mem[30]", rd, 32'h5a5a_0f0f);
		end_test("back-pressure");

		// Chain of L_mult then L_mac into it then a shift and a normalize
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		wb_write(10'h040, a);
		wb_write(10'h041, b);
		wb_write(10'h042, c);
		e1 = expected_result(bops_pkg::OP_L_MULT, a, b, 0, 0);
		e2 = expected_result(bops_pkg::OP_L_MAC, c, b, e1[31:0], 0);
		e3 = expected_result(bops_pkg::OP_L_SHR, e2[31:0], 0, 0, 8'd3);
		e4 = expected_result(bops_pkg::OP_NORM_L, e3[31:0], 0, 0, 0);
		issue_op(bops_pkg::OP_L_MULT, 8'h50, 8'h40, 8'h41);
		wait_idle();
		issue_op(bops_pkg::OP_L_MAC, 8'h50, 8'h42, 8'h41);
		wait_idle();
		issue_op(bops_pkg::OP_L_SHR, 8'h51, 8'h50, 8'd3);
		wait_idle();
		issue_op(bops_pkg::OP_NORM_L, 8'h52, 8'h51, 8'h00);
		wait_idle();
		wb_read(10'h050, rd);
		expect_word("chain L_mac", rd, e2[31:0]);
		wb_read(10'h051, rd);
		expect_word("chain L_shr", rd, e3[31:0]);
		wb_read(10'h052, rd);
		expect_word("chain norm_l", rd, e4[31:0]);
		end_test("chain");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
bops_pkg.sv
bus_pkg.sv
host_port.sv
scratch_mem.sv
op_decode.sv
op_execute.sv
op_result.sv
dsp_top.sv
dsp_chk.sv
dsp_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dsp_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) dsp_tb_ref.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "no result in log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
